/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mprj_ctrl -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* source/mprj_bus_pkg.sv */
package mprj_bus_pkg;

    // Wishbone bus widths
    localparam int WB_AW = 32;
    localparam int WB_DW = 32;
    localparam int WB_SW = WB_DW / 8;

    typedef logic [WB_AW-1:0] wb_addr_t;
    typedef logic [WB_DW-1:0] wb_data_t;
    typedef logic [WB_SW-1:0] wb_sel_t;

    // One 256-byte register page
    localparam int PAGE_W = 8;

    typedef logic [PAGE_W-1:0] reg_ofs_t;

    // Register offsets within the page
    localparam reg_ofs_t DATA_OFS = 8'h00;   // GPIO data
    localparam reg_ofs_t XFER_OFS = 8'h04;   // Transfer start / busy

    // First pad control word; I/O pads first, then power pads, 4-byte stride
    localparam reg_ofs_t CFG_OFS  = 8'h08;

    // Byte address bits below the word index
    localparam int WORD_SHIFT = 2;

endpackage

/* source/mprj_ctrl_regs.sv */
`timescale 1ns/10ps

module mprj_ctrl_regs #(
    parameter mprj_bus_pkg::wb_addr_t BASE_ADR = 32'h2300_0000,
    parameter int IO_PADS  = 16,
    parameter int PWR_PADS = 8
) (
    input  logic                   clk,
    input  logic                   resetn,

    input  mprj_bus_pkg::wb_addr_t wb_adr_i,
    input  mprj_bus_pkg::wb_data_t wb_dat_i,
    input  mprj_bus_pkg::wb_sel_t  wb_sel_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    output mprj_bus_pkg::wb_data_t wb_dat_o,
    output logic                   wb_ack_o,

    input  logic [IO_PADS-1:0]     gpio_in_i,
    output logic [IO_PADS-1:0]     gpio_out_o,
    output logic [IO_PADS-1:0]     gpio_oeb_o,
    output logic [PWR_PADS-1:0]    pwr_ctrl_o,

    mprj_load_if.regs_mp           load
);
    import mprj_bus_pkg::*;
    import mprj_pad_pkg::*;

    io_ctrl_t  io_ctrl [IO_PADS];    // One word per I/O pad
    pwr_ctrl_t pwr_ctrl [PWR_PADS];  // One bit per power pad
    logic [IO_PADS-1:0] gpio_data;
    logic      start_q;

    reg_ofs_t  ofs;
    reg_ofs_t  cfg_rel;
    logic [PAGE_W-WORD_SHIFT-1:0] word_idx;
    logic      cfg_area;
    logic      io_sel;
    logic      pwr_sel;
    logic      wb_req;
    logic      wb_acc;
    logic      wb_wr;
    wb_data_t  rd_data;

    // Page and offset decode
    assign ofs      = wb_adr_i[PAGE_W-1:0];
    assign wb_req   = wb_cyc_i && wb_stb_i
                    && (wb_adr_i[WB_AW-1:PAGE_W] == BASE_ADR[WB_AW-1:PAGE_W]);
    assign wb_acc   = wb_req && !wb_ack_o;        // Accepted on this edge
    assign wb_wr    = wb_acc && wb_we_i && wb_sel_i[0];

    assign cfg_rel  = ofs - CFG_OFS;
    assign word_idx = cfg_rel[PAGE_W-1:WORD_SHIFT];
    assign cfg_area = (ofs >= CFG_OFS) && (ofs[WORD_SHIFT-1:0] == '0);
    assign io_sel   = cfg_area && (int'(word_idx) < IO_PADS);
    assign pwr_sel  = cfg_area && (int'(word_idx) >= IO_PADS)
                    && (int'(word_idx) < IO_PADS + PWR_PADS);

    always_comb begin
        rd_data = '0;                              // Unmapped offsets read 0
        if (ofs == DATA_OFS) begin
            rd_data = wb_data_t'(gpio_in_i);
        end else if (ofs == XFER_OFS) begin
            rd_data = wb_data_t'(load.busy);
        end
        for (int i = 0; i < IO_PADS; i++) begin
            if (io_sel && int'(word_idx) == i) begin
                rd_data = wb_data_t'(io_ctrl[i]);
            end
        end
        for (int j = 0; j < PWR_PADS; j++) begin
            if (pwr_sel && int'(word_idx) == IO_PADS + j) begin
                rd_data = wb_data_t'(pwr_ctrl[j]);
            end
        end
    end

    // Ack and register writes
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_ack_o  <= 1'b0;
            start_q   <= 1'b0;
            gpio_data <= '0;
            io_ctrl   <= '{default: '0};
            pwr_ctrl  <= '{default: '0};
        end else begin
            wb_ack_o <= wb_acc;
            start_q  <= 1'b0;
            if (wb_wr) begin
                if (ofs == DATA_OFS) begin
                    gpio_data <= wb_dat_i[IO_PADS-1:0];
                end
                // Start is dropped while a load runs
                if (ofs == XFER_OFS && wb_dat_i[0] && !load.busy) begin
                    start_q <= 1'b1;
                end
                for (int i = 0; i < IO_PADS; i++) begin
                    if (io_sel && int'(word_idx) == i) begin
                        io_ctrl[i] <= wb_dat_i[IO_CTRL_BITS-1:0];
                    end
                end
                for (int j = 0; j < PWR_PADS; j++) begin
                    if (pwr_sel && int'(word_idx) == IO_PADS + j) begin
                        pwr_ctrl[j] <= wb_dat_i[PWR_CTRL_BITS-1:0];
                    end
                end
            end
        end
    end

    // Read data captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (wb_acc) begin
            wb_dat_o <= rd_data;
        end
    end

    assign load.start     = start_q;
    assign load.ctrl_word = io_ctrl[load.pad_idx];  // Word for the loader to fetch

    assign gpio_out_o = gpio_data;

    for (genvar i = 0; i < IO_PADS; i++) begin : g_oeb
        assign gpio_oeb_o[i] = io_ctrl[i][OEB_BIT];
    end

    for (genvar j = 0; j < PWR_PADS; j++) begin : g_pwr
        assign pwr_ctrl_o[j] = pwr_ctrl[j][0];  // Pad 0 in the LSB
    end

endmodule

/* source/mprj_ctrl_top.sv */
`timescale 1ns/10ps

module mprj_ctrl_top #(
    parameter mprj_bus_pkg::wb_addr_t BASE_ADR = 32'h2300_0000,
    parameter int IO_PADS  = 16,
    parameter int PWR_PADS = 8
) (
    input  logic                   clk,
    input  logic                   resetn,

    // Wishbone slave
    input  mprj_bus_pkg::wb_addr_t wb_adr_i,
    input  mprj_bus_pkg::wb_data_t wb_dat_i,
    input  mprj_bus_pkg::wb_sel_t  wb_sel_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    output mprj_bus_pkg::wb_data_t wb_dat_o,
    output logic                   wb_ack_o,

    // Serial chain to the pad control shift registers
    output logic                   serial_clock_o,
    output logic                   serial_resetn_o,
    output logic                   serial_data_o,

    // Pads
    input  logic [IO_PADS-1:0]     gpio_in_i,
    output logic [IO_PADS-1:0]     gpio_out_o,
    output logic [IO_PADS-1:0]     gpio_oeb_o,
    output logic [PWR_PADS-1:0]    pwr_ctrl_o
);

    mprj_load_if #(.IO_PADS(IO_PADS)) load_bus ();

    mprj_ctrl_regs #(
        .BASE_ADR (BASE_ADR),
        .IO_PADS  (IO_PADS),
        .PWR_PADS (PWR_PADS)
    ) u_regs (
        .clk        (clk),
        .resetn     (resetn),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oeb_o (gpio_oeb_o),
        .pwr_ctrl_o (pwr_ctrl_o),
        .load       (load_bus.regs_mp)
    );

    mprj_serial_loader #(
        .IO_PADS (IO_PADS)
    ) u_loader (
        .clk             (clk),
        .resetn          (resetn),
        .load            (load_bus.loader_mp),
        .serial_clock_o  (serial_clock_o),
        .serial_resetn_o (serial_resetn_o),
        .serial_data_o   (serial_data_o)
    );

endmodule

/* source/mprj_load_if.sv */
`timescale 1ns/10ps

interface mprj_load_if #(
    parameter int IO_PADS = 16
);
    import mprj_pad_pkg::*;

    localparam int IDX_W = $clog2(IO_PADS);

    logic             start;      // One-cycle load request
    logic             busy;       // Load in progress
    logic [IDX_W-1:0] pad_idx;    // Pad being fetched
    io_ctrl_t         ctrl_word;  // Control word of pad_idx

    modport regs_mp (output start, output ctrl_word, input busy, input pad_idx);

    modport loader_mp (input start, input ctrl_word, output busy, output pad_idx);

endinterface

/* source/mprj_pad_pkg.sv */
package mprj_pad_pkg;

    // I/O pad control word
    localparam int IO_CTRL_BITS = 14;

    typedef logic [IO_CTRL_BITS-1:0] io_ctrl_t;

    // Power pad control
    localparam int PWR_CTRL_BITS = 1;

    typedef logic [PWR_CTRL_BITS-1:0] pwr_ctrl_t;

    // Output enable bar inside io_ctrl_t, low drives the pad
    localparam int OEB_BIT = 1;

    // Bit position within one control word while shifting
    typedef logic [3:0] bit_cnt_t;

    // Serial loader states
    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_FETCH,   // Copy one pad word into staging
        LOAD_SHIFT,   // Two cycles per bit
        LOAD_LATCH    // Strobe serial_resetn low
    } load_state_t;

endpackage

/* source/mprj_serial_loader.sv */
`timescale 1ns/10ps

module mprj_serial_loader #(
    parameter int IO_PADS = 16
) (
    input  logic clk,
    input  logic resetn,

    mprj_load_if.loader_mp load,

    output logic serial_clock_o,
    output logic serial_resetn_o,
    output logic serial_data_o
);
    import mprj_pad_pkg::*;

    localparam int IDX_W = $clog2(IO_PADS);
    localparam logic [IDX_W-1:0] LAST_PAD = IDX_W'(IO_PADS - 1);
    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(IO_CTRL_BITS - 1);

    load_state_t      state;
    logic [IDX_W-1:0] pad_cnt;
    bit_cnt_t         bit_cnt;
    io_ctrl_t         staging;   // Remaining bits, next one at the MSB

    assign load.busy    = (state != LOAD_IDLE);
    assign load.pad_idx = pad_cnt;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state           <= LOAD_IDLE;
            pad_cnt         <= '0;
            bit_cnt         <= '0;
            serial_clock_o  <= 1'b0;
            serial_resetn_o <= 1'b0;     // Chain held in reset with us
            serial_data_o   <= 1'b0;
        end else begin
            serial_resetn_o <= 1'b1;
            case (state)
                LOAD_IDLE: begin
                    serial_clock_o <= 1'b0;
                    if (load.start) begin
                        pad_cnt <= '0;
                        state   <= LOAD_FETCH;
                    end
                end
                LOAD_FETCH: begin
                    bit_cnt       <= '0;
                    serial_data_o <= load.ctrl_word[IO_CTRL_BITS-1];  // MSB first
                    state         <= LOAD_SHIFT;
                end
                LOAD_SHIFT: begin
                    serial_clock_o <= !serial_clock_o;
                    // Clock high cycle done, move to the next bit
                    if (serial_clock_o) begin
                        if (bit_cnt == LAST_BIT) begin
                            if (pad_cnt == LAST_PAD) begin
                                serial_resetn_o <= 1'b0;   // Latch strobe
                                serial_data_o   <= 1'b0;
                                state           <= LOAD_LATCH;
                            end else begin
                                pad_cnt <= pad_cnt + 1'b1;
                                state   <= LOAD_FETCH;
                            end
                        end else begin
                            bit_cnt       <= bit_cnt + 1'b1;
                            serial_data_o <= staging[IO_CTRL_BITS-1];
                        end
                    end
                end
                LOAD_LATCH: begin
                    serial_clock_o <= 1'b0;
                    state          <= LOAD_IDLE;
                end
                default: begin
                    state <= LOAD_IDLE;
                end
            endcase
        end
    end

    // Staging shifts as each new bit is put on the line
    always_ff @(posedge clk) begin
        if (state == LOAD_FETCH) begin
            staging <= {load.ctrl_word[IO_CTRL_BITS-2:0], 1'b0};
        end else if (state == LOAD_SHIFT && serial_clock_o) begin
            staging <= {staging[IO_CTRL_BITS-2:0], 1'b0};
        end
    end

endmodule

/* tests/tb_mprj_tasks.svh */
    logic [31:0] lcg_state = 32'hb892_e52b;
    logic [13:0] ctrl_model [IO_PADS];    // Expected I/O control words

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Power pads follow directly after the I/O pads
    function automatic logic [31:0] cfg_adr(input int idx);
        return BASE_ADR + 32'h8 + 32'(4 * idx);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // One access, stb dropped on ack or after 8 cycles
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             input logic [3:0] sel, output logic [31:0] rdata,
                             output logic acked);
        int n;
        acked = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i} = {2'b11, we, sel};
        wb_adr_i = adr;
        wb_dat_i = wdata;
        for (n = 0; n < 8 && !acked; n++) begin
            @(posedge clk);
            #1;
            acked = wb_ack_o;
            rdata = wb_dat_o;
        end
        {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdata,
                            input logic [3:0] sel);
        logic [31:0] rdata;
        logic        acked;
        bus_cycle(1'b1, adr, wdata, sel, rdata, acked);
        if (!acked) begin
            error_count++;
            $display("Error at %0t: write to %h was never acknowledged", $time, adr);
        end
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdata);
        logic acked;
        bus_cycle(1'b0, adr, '0, 4'hf, rdata, acked);
        if (!acked) begin
            error_count++;
            $display("Error at %0t: read from %h was never acknowledged", $time, adr);
        end
    endtask

    task automatic read_check(input string name, input logic [31:0] adr,
                              input logic [31:0] expected);
        logic [31:0] rdata;
        wb_read(adr, rdata);
        check_value(name, expected, rdata);
    endtask

    task automatic wait_for_latch(input int start_count);
        int n;
        for (n = 0; n < LOAD_CYCLES + 8 && latch_count == start_count; n++) begin
            @(posedge clk);
        end
        if (latch_count == start_count) begin
            error_count++;
            $display("Error at %0t: no latch pulse within %0d cycles", $time, LOAD_CYCLES + 8);
        end
    endtask

    // Pad 0 first, each word MSB first
    task automatic compare_chain_bits();
        check_value("serial bit count", 32'(IO_PADS * 14), 32'(serial_bits.size()));
        for (int k = 0; k < IO_PADS * 14 && k < serial_bits.size(); k++) begin
            check_value($sformatf("serial bit %0d", k), 32'(ctrl_model[k / 14][13 - k % 14]),
                        32'(serial_bits[k]));
        end
    endtask

    task automatic write_random_words();
        logic [31:0] value;
        for (int i = 0; i < IO_PADS; i++) begin
            value = next_random();
            ctrl_model[i] = value[13:0];
            wb_write(cfg_adr(i), value, 4'hf);
        end
    endtask

    task automatic verify_reset_values();
        read_check("DATA", BASE_ADR, 0);
        read_check("XFER", XFER_ADR, 0);
        for (int i = 0; i < IO_PADS + PWR_PADS; i++) begin
            read_check($sformatf("cfg[%0d]", i), cfg_adr(i), 0);
        end
        check_value("gpio_out_o", 0, 32'(gpio_out_o));
        check_value("gpio_oeb_o", 0, 32'(gpio_oeb_o));
        check_value("pwr_ctrl_o", 0, 32'(pwr_ctrl_o));
        check_value("serial_clock_o", 0, 32'(serial_clock_o));
        check_value("serial_data_o", 0, 32'(serial_data_o));
        check_value("serial_resetn_o", 1, 32'(serial_resetn_o));
    endtask

    task automatic exercise_control_words();
        write_random_words();
        for (int i = 0; i < IO_PADS; i++) begin
            read_check($sformatf("ctrl[%0d]", i), cfg_adr(i), 32'(ctrl_model[i]));
        end
        wb_write(cfg_adr(3), {18'h0, ~ctrl_model[3]}, 4'b1110);   // Byte lane 0 off
        read_check("ctrl[3] after sel[0] low", cfg_adr(3), 32'(ctrl_model[3]));
    endtask

    task automatic exercise_power_and_pads();
        logic [31:0]         value;
        logic [PWR_PADS-1:0] pwr_bits;
        logic [IO_PADS-1:0]  oeb_bits;
        value = next_random();
        pwr_bits = value[PWR_PADS-1:0];
        for (int j = 0; j < PWR_PADS; j++) begin
            value = next_random();
            value[0] = pwr_bits[j];
            wb_write(cfg_adr(IO_PADS + j), value, 4'hf);
        end
        check_value("pwr_ctrl_o", 32'(pwr_bits), 32'(pwr_ctrl_o));
        for (int j = 0; j < PWR_PADS; j++) begin
            read_check($sformatf("pwr[%0d]", j), cfg_adr(IO_PADS + j), 32'(pwr_bits[j]));
        end
        value = next_random();
        wb_write(BASE_ADR, value, 4'hf);
        check_value("gpio_out_o", 32'(value[IO_PADS-1:0]), 32'(gpio_out_o));
        for (int i = 0; i < IO_PADS; i++) begin
            oeb_bits[i] = ctrl_model[i][1];
        end
        check_value("gpio_oeb_o", 32'(oeb_bits), 32'(gpio_oeb_o));
        value = next_random();
        gpio_in_i = value[IO_PADS-1:0];
        read_check("DATA from gpio_in_i", BASE_ADR, 32'(value[IO_PADS-1:0]));
    endtask

    task automatic run_serial_load();
        int latches;
        write_random_words();
        serial_bits.delete();
        latches = latch_count;
        wb_write(XFER_ADR, 32'h1, 4'hf);
        read_check("XFER during load", XFER_ADR, 1);
        wait_for_latch(latches);
        read_check("XFER after load", XFER_ADR, 0);
        check_value("latch pulses", 32'(latches + 1), 32'(latch_count));
        compare_chain_bits();
    endtask

    task automatic ignore_busy_start();
        int latches;
        serial_bits.delete();
        latches = latch_count;
        wb_write(XFER_ADR, 32'h1, 4'hf);
        repeat (LOAD_CYCLES / 2) @(posedge clk);
        wb_write(XFER_ADR, 32'h1, 4'hf);    // Mid-load start
        read_check("XFER after second start", XFER_ADR, 1);
        wait_for_latch(latches);
        repeat (40) @(posedge clk);          // Room for a restarted load to show
        read_check("XFER after ignored start", XFER_ADR, 0);
        check_value("latch pulses", 32'(latches + 1), 32'(latch_count));
        compare_chain_bits();
    endtask

    task automatic probe_address_decode();
        logic [31:0] rdata;
        logic        acked;
        bus_cycle(1'b0, cfg_adr(IO_PADS + PWR_PADS), '0, 4'hf, rdata, acked);
        check_value("ack at unmapped offset", 1, 32'(acked));
        check_value("read at unmapped offset", 0, rdata);
        // ctrl[0] offset, one page up
        bus_cycle(1'b1, BASE_ADR + 32'h108, 32'h3fff, 4'hf, rdata, acked);
        check_value("ack from another page", 0, 32'(acked));
        read_check("ctrl[0] after other page write", cfg_adr(0), 32'(ctrl_model[0]));
    endtask

/* tests/tb_mprj_ctrl.sv */
`timescale 1ns/10ps

module tb_mprj_ctrl;

    localparam logic [31:0] BASE_ADR = 32'h2300_0000;
    localparam logic [31:0] XFER_ADR = BASE_ADR + 32'h4;
    localparam int IO_PADS        = 16;
    localparam int PWR_PADS       = 8;
    localparam int LOAD_CYCLES    = IO_PADS * 29 + 2;
    localparam int TIMEOUT_CYCLES = 2000;   // Two loads of 466 cycles and the bus traffic

    logic                clk      = 1'b0;
    logic                resetn   = 1'b0;
    logic [31:0]         wb_adr_i = '0;
    logic [31:0]         wb_dat_i = '0;
    logic [3:0]          wb_sel_i = '0;
    logic                wb_cyc_i = 1'b0;
    logic                wb_stb_i = 1'b0;
    logic                wb_we_i  = 1'b0;
    logic [31:0]         wb_dat_o;
    logic                wb_ack_o;
    logic                serial_clock_o;
    logic                serial_resetn_o;
    logic                serial_data_o;
    logic [IO_PADS-1:0]  gpio_in_i = '0;
    logic [IO_PADS-1:0]  gpio_out_o;
    logic [IO_PADS-1:0]  gpio_oeb_o;
    logic [PWR_PADS-1:0] pwr_ctrl_o;

    int   error_count = 0;
    int   cycle_count = 0;
    int   latch_count = 0;
    logic serial_bits[$];      // Data seen at each serial clock rise
    logic sclk_prev = 1'b0;
    logic chain_up  = 1'b0;    // Chain has left reset

    mprj_ctrl_top #(
        .BASE_ADR (BASE_ADR),
        .IO_PADS  (IO_PADS),
        .PWR_PADS (PWR_PADS)
    ) u_dut (.*);

    always #2 clk = ~clk;

    `include "tb_mprj_tasks.svh"

    // Shift chain model, sampled mid-cycle
    always @(negedge clk) begin
        if (serial_clock_o && !sclk_prev) begin
            serial_bits.push_back(serial_data_o);
        end
        if (serial_resetn_o) begin
            chain_up = 1'b1;
        end else if (chain_up) begin
            latch_count++;     // A longer pulse counts twice
            check_value("serial_clock_o at latch", 0, 32'(serial_clock_o));
        end
        sclk_prev = serial_clock_o;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        verify_reset_values();
        exercise_control_words();
        exercise_power_and_pads();
        run_serial_load();
        ignore_busy_start();
        probe_address_decode();
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tests
source/mprj_bus_pkg.sv
source/mprj_pad_pkg.sv
source/mprj_load_if.sv
source/mprj_ctrl_regs.sv
source/mprj_serial_loader.sv
source/mprj_ctrl_top.sv
tests/tb_mprj_ctrl.sv
